// ==== source/nlb_pkg.sv ====
/*
  Shared widths, MMIO offsets, test modes and bus structs of the loopback engine.
  Offsets are byte offsets of 64-bit registers. Only LPBK1, READ and WRITE exist.
  FIFO_DEPTH must be a power of two so the FIFO pointers wrap naturally.
*/
package nlb_pkg;

   // ----------------------------------------
   // Widths and sizes
   // ----------------------------------------
   localparam int LINE_W     = 64;
   localparam int ADDR_W     = 20;
   localparam int TID_W      = 16;
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_AFULL = 6;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   // MMIO register map
   localparam logic [15:0] REG_SCRATCH    = 16'h0100;
   localparam logic [15:0] REG_SRC_ADDR   = 16'h0120;
   localparam logic [15:0] REG_DST_ADDR   = 16'h0128;
   localparam logic [15:0] REG_NUM_LINES  = 16'h0130;
   localparam logic [15:0] REG_CTL        = 16'h0138;
   localparam logic [15:0] REG_CFG        = 16'h0140;
   localparam logic [15:0] REG_STATUS     = 16'h0160;
   localparam logic [15:0] REG_NUM_READS  = 16'h0168;
   localparam logic [15:0] REG_NUM_WRITES = 16'h0170;

   // Test modes as found in CFG[4:2]
   localparam logic [2:0] MODE_LPBK1 = 3'd0;
   localparam logic [2:0] MODE_READ  = 3'd1;
   localparam logic [2:0] MODE_WRITE = 3'd2;

   // ----------------------------------------
   // Bus structs
   // ----------------------------------------
   typedef struct packed {
      logic        wr_en;
      logic        rd_en;
      logic [15:0] offset;
      logic [63:0] data;
   } mmio_req_t;

   typedef struct packed {
      logic        valid;
      logic [63:0] data;
   } mmio_rsp_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [TID_W-1:0]  tag;
   } mem_rd_req_t;

   typedef struct packed {
      logic              valid;
      logic [TID_W-1:0]  tag;
      logic [LINE_W-1:0] data;
   } mem_rd_rsp_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] data;
   } mem_wr_req_t;

   // Test setup handed from the register file to both engines
   typedef struct packed {
      logic              go;
      logic              test_rst_n;  // low while the test is held in reset
      logic [2:0]        mode;
      logic [ADDR_W-1:0] src_addr;
      logic [ADDR_W-1:0] dst_addr;
      logic [TID_W-1:0]  num_lines;
   } test_cfg_t;

   // CTL view of a write word
   typedef struct packed {
      logic [61:0] rsvd;
      logic        start;
      logic        test_rst_n;
   } ctl_word_t;

   // CFG view of a write word
   typedef struct packed {
      logic [35:0] rsvd_hi;
      logic [7:0]  test_cfg;
      logic [14:0] rsvd_mid;
      logic [2:0]  mode;
      logic [1:0]  rsvd_lo;
   } cfg_word_t;

   typedef union packed {
      ctl_word_t ctl;
      cfg_word_t cfg;
   } csr_wdata_u;

endpackage

// ==== source/nlb_csr.sv ====
/*
  MMIO register file. Writes land one cycle after the strobe and reads answer
  exactly one cycle after the strobe. SRC, DST, NUM_LINES and CFG are locked
  while CTL start is set. Unmapped offsets read as zero.
*/
`timescale 1ns/1ps

module nlb_csr
   import nlb_pkg::*;
(
   input  logic             Clk_100,
   input  logic             rst_n,
   input  mmio_req_t        mmio_req,
   input  logic             rd_done,
   input  logic             wr_done,
   input  logic [TID_W-1:0] rd_count,
   input  logic [TID_W-1:0] wr_count,
   output mmio_rsp_t        mmio_rsp,
   output test_cfg_t        cfg
);

   csr_wdata_u        wdata;
   csr_wdata_u        ctl_word;
   csr_wdata_u        cfg_word;
   logic [63:0]       scratch;
   logic [ADDR_W-1:0] src_addr;
   logic [ADDR_W-1:0] dst_addr;
   logic [TID_W-1:0]  num_lines;
   logic              ctl_start;
   logic              ctl_rst_n;
   logic [2:0]        mode;
   logic [7:0]        test_cfg;
   logic              wr_locked;
   logic [63:0]       rd_mux;

   // Same write word seen as CTL or as CFG
   assign wdata     = mmio_req.data;
   assign wr_locked = ctl_start;

   // ----------------------------------------
   // Register writes
   // ----------------------------------------
   always_ff @(posedge Clk_100) begin
      if (!rst_n) begin
         src_addr  <= '0;
         dst_addr  <= '0;
         num_lines <= '0;
         ctl_start <= 1'b0;
         ctl_rst_n <= 1'b0;
         mode      <= MODE_LPBK1;
         test_cfg  <= '0;
      end else if (mmio_req.wr_en) begin
         case (mmio_req.offset)
            REG_SCRATCH: scratch <= mmio_req.data;
            // CTL stays writable so a running test can be stopped
            REG_CTL: begin
               ctl_rst_n <= wdata.ctl.test_rst_n;
               ctl_start <= wdata.ctl.start;
            end
            REG_SRC_ADDR: begin
               if (!wr_locked) src_addr <= mmio_req.data[ADDR_W-1:0];
            end
            REG_DST_ADDR: begin
               if (!wr_locked) dst_addr <= mmio_req.data[ADDR_W-1:0];
            end
            REG_NUM_LINES: begin
               if (!wr_locked) num_lines <= mmio_req.data[TID_W-1:0];
            end
            REG_CFG: begin
               if (!wr_locked) begin
                  mode     <= wdata.cfg.mode;
                  test_cfg <= wdata.cfg.test_cfg;
               end
            end
            default: ;
         endcase
      end
   end

   // ----------------------------------------
   // Read mux and response
   // ----------------------------------------
   always_comb begin
      // Rebuild CTL and CFG in their write layout
      ctl_word              = '0;
      ctl_word.ctl.start    = ctl_start;
      ctl_word.ctl.test_rst_n = ctl_rst_n;
      cfg_word              = '0;
      cfg_word.cfg.mode     = mode;
      cfg_word.cfg.test_cfg = test_cfg;
      case (mmio_req.offset)
         REG_SCRATCH:    rd_mux = scratch;
         REG_SRC_ADDR:   rd_mux = 64'(src_addr);
         REG_DST_ADDR:   rd_mux = 64'(dst_addr);
         REG_NUM_LINES:  rd_mux = 64'(num_lines);
         REG_CTL:        rd_mux = ctl_word;
         REG_CFG:        rd_mux = cfg_word;
         // Completion flag in bit 0
         REG_STATUS:     rd_mux = 64'(rd_done & wr_done);
         REG_NUM_READS:  rd_mux = 64'(rd_count);
         REG_NUM_WRITES: rd_mux = 64'(wr_count);
         default:        rd_mux = '0;
      endcase
   end

   always_ff @(posedge Clk_100) begin
      mmio_rsp.data <= rd_mux;
      if (!rst_n) begin
         mmio_rsp.valid <= 1'b0;
      end else begin
         mmio_rsp.valid <= mmio_req.rd_en;
      end
   end

   // Engines run only with start set and test reset released
   assign cfg.go         = ctl_start & ctl_rst_n;
   assign cfg.test_rst_n = ctl_rst_n;
   assign cfg.mode       = mode;
   assign cfg.src_addr   = src_addr;
   assign cfg.dst_addr   = dst_addr;
   assign cfg.num_lines  = num_lines;

endmodule

// ==== source/nlb_rd_engine.sv ====
/*
  Source line reader for LPBK1 and READ modes. Tags are line indexes.
  In LPBK1 the reads in flight plus the FIFO fill never exceed FIFO_DEPTH,
  so memory responses are never refused.
*/
`timescale 1ns/1ps

module nlb_rd_engine
   import nlb_pkg::*;
(
   input  logic             Clk_100,
   input  logic             rst_n,
   input  test_cfg_t        cfg,
   input  logic             fifo_afull,
   input  mem_rd_rsp_t      mem_rd_rsp,
   output mem_rd_req_t      mem_rd_req,
   output mem_rd_rsp_t      push,
   output logic             rd_done,
   output logic [TID_W-1:0] rd_count
);

   logic             lpbk;
   logic             active;
   logic             room;
   logic             issue;
   logic [TID_W-1:0] rd_idx;
   logic [TID_W-1:0] pend;

   assign lpbk   = (cfg.mode == MODE_LPBK1);
   assign active = cfg.go && (lpbk || cfg.mode == MODE_READ);

   // LPBK1 stalls on afull and keeps the in-flight reads within the FIFO headroom
   assign room = !lpbk ||
                 (!fifo_afull && pend < TID_W'(FIFO_DEPTH - FIFO_AFULL));

   // One read per cycle until all lines are requested
   assign issue = active && (rd_idx < cfg.num_lines) && room;

   // ----------------------------------------
   // Request and FIFO push
   // ----------------------------------------
   assign mem_rd_req.valid = issue;
   assign mem_rd_req.addr  = cfg.src_addr + ADDR_W'(rd_idx);
   assign mem_rd_req.tag   = rd_idx;

   // READ mode drops the data
   assign push.valid = mem_rd_rsp.valid && lpbk;
   assign push.tag   = mem_rd_rsp.tag;
   assign push.data  = mem_rd_rsp.data;

   // ----------------------------------------
   // Index and response counters
   // ----------------------------------------
   always_ff @(posedge Clk_100) begin
      if (!rst_n || !cfg.test_rst_n) begin
         rd_idx   <= '0;
         pend     <= '0;
         rd_count <= '0;
      end else begin
         if (issue) begin
            rd_idx <= rd_idx + TID_W'(1);
         end
         if (mem_rd_rsp.valid) begin
            rd_count <= rd_count + TID_W'(1);
         end
         pend <= pend + TID_W'(issue) - TID_W'(mem_rd_rsp.valid);
      end
   end

   // WRITE mode has nothing to read
   assign rd_done = (active && rd_count == cfg.num_lines) ||
                    (cfg.go && cfg.mode == MODE_WRITE);

endmodule

// ==== source/nlb_line_fifo.sv ====
/*
  Line buffer between the read and write engines. Circular buffer of
  FIFO_DEPTH entries with a fill counter. A push into a full buffer is lost,
  which the read engine prevents. A pop of an empty buffer is ignored.
*/
`timescale 1ns/1ps

module nlb_line_fifo
   import nlb_pkg::*;
(
   input  logic        Clk_100,
   input  logic        rst_n,
   input  logic        clear,
   input  mem_rd_rsp_t push,
   input  logic        pop,
   output mem_rd_rsp_t head,
   output logic        empty,
   output logic        afull
);

   logic [TID_W-1:0]      tag_mem  [FIFO_DEPTH];
   logic [LINE_W-1:0]     data_mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] fill;
   logic                  do_pop;

   assign do_pop = pop && !empty;

   // Storage
   always_ff @(posedge Clk_100) begin
      if (push.valid) begin
         tag_mem[wr_ptr]  <= push.tag;
         data_mem[wr_ptr] <= push.data;
      end
   end

   // Pointers and fill level
   always_ff @(posedge Clk_100) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push.valid) begin
            wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
         end
         fill <= fill + FIFO_CNT_W'(push.valid) - FIFO_CNT_W'(do_pop);
      end
   end

   assign empty      = (fill == '0);
   assign afull      = (fill >= FIFO_CNT_W'(FIFO_AFULL));
   assign head.valid = !empty;
   assign head.tag   = tag_mem[rd_ptr];
   assign head.data  = data_mem[rd_ptr];

endmodule

// ==== source/nlb_wr_engine.sv ====
/*
  Destination line writer. LPBK1 drains the line FIFO and WRITE generates
  the line index as data. The request is combinational so it is never
  valid in a cycle with mem_wr_afull high. Done counts write acknowledges.
*/
`timescale 1ns/1ps

module nlb_wr_engine
   import nlb_pkg::*;
(
   input  logic             Clk_100,
   input  logic             rst_n,
   input  test_cfg_t        cfg,
   input  mem_rd_rsp_t      head,
   input  logic             empty,
   input  logic             mem_wr_afull,
   input  logic             mem_wr_ack,
   output logic             pop,
   output mem_wr_req_t      mem_wr_req,
   output logic             wr_done,
   output logic [TID_W-1:0] wr_count
);

   logic             lpbk;
   logic             wmode;
   logic             active;
   logic             have_line;
   logic             issue;
   logic [TID_W-1:0] wr_idx;

   assign lpbk   = (cfg.mode == MODE_LPBK1);
   assign wmode  = (cfg.mode == MODE_WRITE);
   assign active = cfg.go && (lpbk || wmode);

   // A line is ready when buffered or still to be generated
   assign have_line = lpbk ? !empty : (wr_idx < cfg.num_lines);

   // Memory back-pressure holds every write
   assign issue = active && have_line && !mem_wr_afull;
   assign pop   = issue && lpbk;

   // ----------------------------------------
   // Write request
   // ----------------------------------------
   always_comb begin
      mem_wr_req.valid = issue;
      if (lpbk) begin
         // Copied line goes to the same offset as its source
         mem_wr_req.addr = cfg.dst_addr + ADDR_W'(head.tag);
         mem_wr_req.data = head.data;
      end else begin
         // Pattern line carries its own index
         mem_wr_req.addr = cfg.dst_addr + ADDR_W'(wr_idx);
         mem_wr_req.data = LINE_W'(wr_idx);
      end
   end

   // ----------------------------------------
   // Issue and acknowledge counters
   // ----------------------------------------
   always_ff @(posedge Clk_100) begin
      if (!rst_n || !cfg.test_rst_n) begin
         wr_idx   <= '0;
         wr_count <= '0;
      end else begin
         // Lines sent so far
         if (issue) begin
            wr_idx <= wr_idx + TID_W'(1);
         end
         // Lines the memory has taken
         if (mem_wr_ack) begin
            wr_count <= wr_count + TID_W'(1);
         end
      end
   end

   // READ mode writes nothing
   assign wr_done = (active && wr_count == cfg.num_lines) ||
                    (cfg.go && cfg.mode == MODE_READ);

endmodule

// ==== source/nlb_top.sv ====
/*
  Loopback test engine top. MMIO programs the test and the memory ports
  carry single 64-bit lines. mem_wr_afull is a level that holds writes.
*/
`timescale 1ns/1ps

module nlb_top
   import nlb_pkg::*;
(
   input  logic        Clk_100,
   input  logic        rst_n,
   input  mmio_req_t   mmio_req,
   input  mem_rd_rsp_t mem_rd_rsp,
   input  logic        mem_wr_ack,
   input  logic        mem_wr_afull,
   output mmio_rsp_t   mmio_rsp,
   output mem_rd_req_t mem_rd_req,
   output mem_wr_req_t mem_wr_req
);

   test_cfg_t        cfg;
   logic             rd_done;
   logic             wr_done;
   logic [TID_W-1:0] rd_count;
   logic [TID_W-1:0] wr_count;
   mem_rd_rsp_t      push;
   mem_rd_rsp_t      head;
   logic             fifo_afull;
   logic             fifo_empty;
   logic             pop;

   // Register file
   nlb_csr u_csr (
      .Clk_100  (Clk_100),
      .rst_n    (rst_n),
      .mmio_req (mmio_req),
      .rd_done  (rd_done),
      .wr_done  (wr_done),
      .rd_count (rd_count),
      .wr_count (wr_count),
      .mmio_rsp (mmio_rsp),
      .cfg      (cfg)
   );

   nlb_rd_engine u_rd_engine (
      .Clk_100    (Clk_100),
      .rst_n      (rst_n),
      .cfg        (cfg),
      .fifo_afull (fifo_afull),
      .mem_rd_rsp (mem_rd_rsp),
      .mem_rd_req (mem_rd_req),
      .push       (push),
      .rd_done    (rd_done),
      .rd_count   (rd_count)
   );

   // Test reset empties the buffer
   nlb_line_fifo u_fifo (
      .Clk_100 (Clk_100),
      .rst_n   (rst_n),
      .clear   (!cfg.test_rst_n),
      .push    (push),
      .pop     (pop),
      .head    (head),
      .empty   (fifo_empty),
      .afull   (fifo_afull)
   );

   nlb_wr_engine u_wr_engine (
      .Clk_100      (Clk_100),
      .rst_n        (rst_n),
      .cfg          (cfg),
      .head         (head),
      .empty        (fifo_empty),
      .mem_wr_afull (mem_wr_afull),
      .mem_wr_ack   (mem_wr_ack),
      .pop          (pop),
      .mem_wr_req   (mem_wr_req),
      .wr_done      (wr_done),
      .wr_count     (wr_count)
   );

endmodule

// ==== verification/tb_clock.sv ====
/*
  Clock and reset source for the testbench.
  Clk_100 runs with a 20 ns period. rst_n is low for the first 16 rising edges.
*/
`timescale 1ns/1ps

module tb_clock (
   output logic Clk_100,
   output logic rst_n
);

   initial begin
      Clk_100 = 1'b0;
      forever #10 Clk_100 = ~Clk_100;
   end

   // Reset released on a rising edge like every other DUT input
   initial begin
      rst_n <= 1'b0;
      repeat (16) @(posedge Clk_100);
      rst_n <= 1'b1;
   end

endmodule

// ==== verification/tb_mem_model.sv ====
/*
  Memory model for the loopback engine. Read data for line address A is
  A XOR DATA_KEY, answered in request order after 1 + delay cycles, at most
  one response per cycle. Nothing is stored. Each write is acked next cycle.
*/
`timescale 1ns/1ps

module tb_mem_model
   import nlb_pkg::*;
#(
   parameter logic [LINE_W-1:0] DATA_KEY = '0
) (
   input  logic        Clk_100,
   input  logic        rst_n,
   input  logic [2:0]  delay,
   input  mem_rd_req_t mem_rd_req,
   input  mem_wr_req_t mem_wr_req,
   output mem_rd_rsp_t mem_rd_rsp,
   output logic        mem_wr_ack
);

   int unsigned       cycle;
   int unsigned       due_q  [$];
   logic [TID_W-1:0]  tag_q  [$];
   logic [ADDR_W-1:0] addr_q [$];

   initial begin
      cycle = 0;
      mem_rd_rsp <= '0;
      mem_wr_ack <= 1'b0;
   end

   always @(posedge Clk_100) begin
      int unsigned       due;
      logic [TID_W-1:0]  tag;
      logic [ADDR_W-1:0] addr;
      if (!rst_n) begin
         due_q.delete();
         tag_q.delete();
         addr_q.delete();
         mem_rd_rsp <= '0;
         mem_wr_ack <= 1'b0;
      end else begin
         // New read joins the queue, never ahead of an older one
         if (mem_rd_req.valid) begin
            due = cycle + 1 + int'(delay);
            if (due_q.size() != 0 && due <= due_q[$]) begin
               due = due_q[$] + 1;
            end
            due_q.push_back(due);
            tag_q.push_back(mem_rd_req.tag);
            addr_q.push_back(mem_rd_req.addr);
         end
         // Oldest read answers once its time has come
         if (due_q.size() != 0 && due_q[0] <= cycle) begin
            tag  = tag_q.pop_front();
            addr = addr_q.pop_front();
            void'(due_q.pop_front());
            mem_rd_rsp <= '{valid: 1'b1, tag: tag, data: LINE_W'(addr) ^ DATA_KEY};
         end else begin
            mem_rd_rsp <= '0;
         end
         mem_wr_ack <= mem_wr_req.valid;
      end
      cycle++;
   end

endmodule

// ==== verification/nlb_checker.sv ====
/*
  Protocol assertions bound into every nlb_top instance.
  Covers MMIO read timing, the mem_wr_afull hold, mode exclusivity of the
  memory ports and quiet valid outputs during reset.
*/
`timescale 1ns/1ps

module nlb_checker
   import nlb_pkg::*;
(
   input logic        Clk_100,
   input logic        rst_n,
   input mmio_req_t   mmio_req,
   input mmio_rsp_t   mmio_rsp,
   input mem_rd_req_t mem_rd_req,
   input mem_wr_req_t mem_wr_req,
   input logic        mem_wr_afull,
   input test_cfg_t   cfg
);

   // Failed assertions so far
   int fail_count = 0;

   // ----------------------------------------
   // MMIO read response timing
   // ----------------------------------------
   a_rsp_after_rd: assert property (@(posedge Clk_100) disable iff (!rst_n)
      mmio_req.rd_en |=> mmio_rsp.valid)
      else begin
         fail_count++;
         $error("MMIO read strobe got no response on the next cycle");
      end

   a_rsp_only_after_rd: assert property (@(posedge Clk_100) disable iff (!rst_n)
      mmio_rsp.valid |-> $past(mmio_req.rd_en))
      else begin
         fail_count++;
         $error("MMIO response valid without a read strobe one cycle before");
      end

   // ----------------------------------------
   // Memory ports
   // ----------------------------------------
   a_no_wr_in_afull: assert property (@(posedge Clk_100) disable iff (!rst_n)
      mem_wr_req.valid |-> !mem_wr_afull)
      else begin
         fail_count++;
         $error("Write request issued while mem_wr_afull is high");
      end

   a_no_wr_in_read: assert property (@(posedge Clk_100) disable iff (!rst_n)
      cfg.mode == MODE_READ |-> !mem_wr_req.valid)
      else begin
         fail_count++;
         $error("Write request seen in READ mode");
      end

   a_no_rd_in_write: assert property (@(posedge Clk_100) disable iff (!rst_n)
      cfg.mode == MODE_WRITE |-> !mem_rd_req.valid)
      else begin
         fail_count++;
         $error("Read request seen in WRITE mode");
      end

   // Outputs settle low within one cycle of reset
   a_quiet_in_reset: assert property (@(posedge Clk_100)
      !rst_n |=> !mem_rd_req.valid && !mem_wr_req.valid && !mmio_rsp.valid)
      else begin
         fail_count++;
         $error("Valid output high after a reset cycle");
      end

endmodule

bind nlb_top nlb_checker u_checker (
   .Clk_100      (Clk_100),
   .rst_n        (rst_n),
   .mmio_req     (mmio_req),
   .mmio_rsp     (mmio_rsp),
   .mem_rd_req   (mem_rd_req),
   .mem_wr_req   (mem_wr_req),
   .mem_wr_afull (mem_wr_afull),
   .cfg          (cfg)
);

// ==== verification/tb_top.sv ====
/*
  Testbench for the loopback engine. Runs scratchpad, LPBK1, READ, WRITE and
  write-lock tests over MMIO against a memory model with random latency.
  Read and write request fields are checked here and port protocol in the bound checker.
  The run is cut off at a cycle limit derived from the test lengths.
*/
`timescale 1ns/1ps

module tb_top
   import nlb_pkg::*;
();

   localparam logic [63:0] DATA_KEY    = 64'hc3a5_96f0_0f69_5a3c;
   localparam int unsigned SEED        = 32'h5ba3_35de;
   localparam int          NUM_TESTS   = 5;
   localparam int          TEST_LINES  = 20 + 12 + 10 + 16;
   localparam int          CYCLE_LIMIT = 40 * TEST_LINES + 200 * NUM_TESTS;

   logic        Clk_100;
   logic        rst_n;
   mmio_req_t   mmio_req;
   mmio_rsp_t   mmio_rsp;
   mem_rd_req_t mem_rd_req;
   mem_rd_rsp_t mem_rd_rsp;
   mem_wr_req_t mem_wr_req;
   logic        mem_wr_ack;
   logic        mem_wr_afull;
   logic [2:0]  rd_delay;
   logic        pause_en;

   // Expected test setup as software programmed it
   logic [2:0]        cur_mode;
   logic [ADDR_W-1:0] cur_src;
   logic [ADDR_W-1:0] cur_dst;
   logic [TID_W-1:0]  cur_lines;

   int errors;
   int mon_errors;
   int test_errors0;
   int tests_passed;
   int tests_failed;
   int cycles;

   tb_clock u_clock (
      .Clk_100 (Clk_100),
      .rst_n   (rst_n)
   );

   tb_mem_model #(.DATA_KEY(DATA_KEY)) u_mem (
      .Clk_100    (Clk_100),
      .rst_n      (rst_n),
      .delay      (rd_delay),
      .mem_rd_req (mem_rd_req),
      .mem_wr_req (mem_wr_req),
      .mem_rd_rsp (mem_rd_rsp),
      .mem_wr_ack (mem_wr_ack)
   );

   nlb_top UUT (
      .Clk_100      (Clk_100),
      .rst_n        (rst_n),
      .mmio_req     (mmio_req),
      .mem_rd_rsp   (mem_rd_rsp),
      .mem_wr_ack   (mem_wr_ack),
      .mem_wr_afull (mem_wr_afull),
      .mmio_rsp     (mmio_rsp),
      .mem_rd_req   (mem_rd_req),
      .mem_wr_req   (mem_wr_req)
   );

   // ----------------------------------------
   // MMIO access
   // ----------------------------------------
   task automatic mmio_write(input logic [15:0] offset, input logic [63:0] data);
      @(posedge Clk_100);
      mmio_req <= '{wr_en: 1'b1, rd_en: 1'b0, offset: offset, data: data};
      @(posedge Clk_100);
      mmio_req <= '0;
   endtask

   task automatic mmio_read(input logic [15:0] offset, output logic [63:0] data);
      int wait_cycles;
      wait_cycles = 0;
      data = '0;
      @(posedge Clk_100);
      mmio_req <= '{wr_en: 1'b0, rd_en: 1'b1, offset: offset, data: 64'h0};
      @(posedge Clk_100);
      mmio_req <= '0;
      // Response is registered on the strobe edge and sampled on the next
      do begin
         @(posedge Clk_100);
         wait_cycles++;
      end while (!mmio_rsp.valid && wait_cycles < 4);
      if (mmio_rsp.valid) begin
         data = mmio_rsp.data;
      end else begin
         $display("No MMIO read response for offset %h", offset);
         errors++;
      end
   endtask

   task automatic check_reg(input string name, input logic [15:0] offset,
                            input logic [63:0] exp);
      logic [63:0] got;
      mmio_read(offset, got);
      assert (got == exp) else begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // ----------------------------------------
   // Test control
   // ----------------------------------------
   task automatic start_test(input logic [2:0] mode, input logic [ADDR_W-1:0] src,
                             input logic [ADDR_W-1:0] dst, input logic [TID_W-1:0] lines);
      // Hold in test reset, program, release, then start
      mmio_write(REG_CTL, 64'h0);
      mmio_write(REG_SRC_ADDR, 64'(src));
      mmio_write(REG_DST_ADDR, 64'(dst));
      mmio_write(REG_NUM_LINES, 64'(lines));
      mmio_write(REG_CFG, 64'(mode) << 2);
      cur_mode  = mode;
      cur_src   = src;
      cur_dst   = dst;
      cur_lines = lines;
      mmio_write(REG_CTL, 64'h1);
      mmio_write(REG_CTL, 64'h3);
   endtask

   // Poll the completion flag until the test is done
   task automatic wait_done();
      logic [63:0] status;
      status = '0;
      while (status[0] !== 1'b1) begin
         mmio_read(REG_STATUS, status);
      end
   endtask

   function automatic int total_errors();
      return errors + mon_errors + UUT.u_checker.fail_count;
   endfunction

   task automatic end_test(input string name);
      int now_errors;
      now_errors = total_errors();
      if (now_errors == test_errors0) begin
         tests_passed++;
         $display("[%0d] %s: passed", tests_passed + tests_failed, name);
      end else begin
         tests_failed++;
         $display("[%0d] %s: %0d error(s)", tests_passed + tests_failed, name,
                  now_errors - test_errors0);
      end
      test_errors0 = now_errors;
   endtask

   // New memory latency and write back-pressure drawn every cycle
   task automatic drive_random();
      forever begin
         @(posedge Clk_100);
         rd_delay     <= 3'($urandom % 8);
         mem_wr_afull <= pause_en && (($urandom % 4) == 0);
      end
   endtask

   // ----------------------------------------
   // Read port monitor
   // ----------------------------------------
   always @(posedge Clk_100) begin
      logic [ADDR_W-1:0] exp_addr;
      // Tags are line indexes and each read targets source plus its index
      exp_addr = cur_src + ADDR_W'(mem_rd_req.tag);
      if (rst_n && mem_rd_req.valid) begin
         assert (mem_rd_req.tag < cur_lines) else begin
            $display("MISMATCH mem_rd_req.tag: got %h, expected below %h",
                     mem_rd_req.tag, cur_lines);
            mon_errors++;
         end
         assert (mem_rd_req.addr == exp_addr) else begin
            $display("MISMATCH mem_rd_req.addr: got %h, expected %h",
                     mem_rd_req.addr, exp_addr);
            mon_errors++;
         end
      end
   end

   // ----------------------------------------
   // Write port monitor
   // ----------------------------------------
   always @(posedge Clk_100) begin
      logic [ADDR_W-1:0] offs;
      logic [63:0]       exp;
      offs = mem_wr_req.addr - cur_dst;
      // WRITE carries the line index and LPBK1 the source line's model data
      if (cur_mode == MODE_WRITE) begin
         exp = 64'(offs);
      end else begin
         exp = 64'(ADDR_W'(cur_src + offs)) ^ DATA_KEY;
      end
      if (rst_n && mem_wr_req.valid) begin
         assert (offs < ADDR_W'(cur_lines)) else begin
            $display("MISMATCH mem_wr_req.addr: got %h, expected %h to %h",
                     mem_wr_req.addr, cur_dst, cur_dst + ADDR_W'(cur_lines) - 1'b1);
            mon_errors++;
         end
         assert (mem_wr_req.data == exp) else begin
            $display("MISMATCH mem_wr_req.data at %h: got %h, expected %h",
                     mem_wr_req.addr, mem_wr_req.data, exp);
            mon_errors++;
         end
      end
   end

   // ----------------------------------------
   // Watchdog
   // ----------------------------------------
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge Clk_100);
         cycles++;
      end
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      logic [63:0] scratch_val;
      void'($urandom(SEED));
      errors       = 0;
      mon_errors   = 0;
      test_errors0 = 0;
      tests_passed = 0;
      tests_failed = 0;
      cur_mode     = MODE_LPBK1;
      cur_src      = '0;
      cur_dst      = '0;
      cur_lines    = '0;
      pause_en     <= 1'b0;
      mmio_req     <= '0;
      mem_wr_afull <= 1'b0;
      rd_delay     <= 3'd0;
      fork
         drive_random();
      join_none
      while (rst_n !== 1'b1) @(posedge Clk_100);

      // Scratchpad and an unmapped offset
      scratch_val = {$urandom, $urandom};
      mmio_write(REG_SCRATCH, scratch_val);
      check_reg("SCRATCH", REG_SCRATCH, scratch_val);
      check_reg("unmapped 0x108", 16'h0108, 64'h0);
      end_test("scratchpad readback");

      start_test(MODE_LPBK1, 20'h01000, 20'h02000, 16'd20);
      wait_done();
      check_reg("STATUS", REG_STATUS, 64'h1);
      check_reg("NUM_READS", REG_NUM_READS, 64'd20);
      check_reg("NUM_WRITES", REG_NUM_WRITES, 64'd20);
      end_test("LPBK1 20 lines");

      start_test(MODE_READ, 20'h03000, 20'h00000, 16'd12);
      wait_done();
      check_reg("STATUS", REG_STATUS, 64'h1);
      check_reg("NUM_READS", REG_NUM_READS, 64'd12);
      check_reg("NUM_WRITES", REG_NUM_WRITES, 64'd0);
      end_test("READ 12 lines");

      pause_en <= 1'b1;
      start_test(MODE_WRITE, 20'h00000, 20'h04000, 16'd10);
      wait_done();
      pause_en <= 1'b0;
      check_reg("STATUS", REG_STATUS, 64'h1);
      check_reg("NUM_WRITES", REG_NUM_WRITES, 64'd10);
      end_test("WRITE 10 lines with pauses");

      // Source write while running must not land
      start_test(MODE_LPBK1, 20'h05000, 20'h06000, 16'd16);
      mmio_write(REG_SRC_ADDR, 64'h07000);
      check_reg("SRC_ADDR", REG_SRC_ADDR, 64'h05000);
      wait_done();
      mmio_write(REG_CTL, 64'h0);
      check_reg("NUM_READS", REG_NUM_READS, 64'd0);
      check_reg("NUM_WRITES", REG_NUM_WRITES, 64'd0);
      check_reg("STATUS", REG_STATUS, 64'h0);
      end_test("write lock and test reset");

      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && total_errors() == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== files.f ====
source/nlb_pkg.sv
source/nlb_csr.sv
source/nlb_rd_engine.sv
source/nlb_line_fifo.sv
source/nlb_wr_engine.sv
source/nlb_top.sv
verification/tb_clock.sv
verification/tb_mem_model.sv
verification/nlb_checker.sv
verification/tb_top.sv

// ==== run.sh ====
#!/bin/bash
# Build the testbench with Verilator, run it and judge the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f -o tb_sim \
   && ./obj_dir/tb_sim +verilator+error+limit+1000 2>&1 | tee sim.log \
   && grep -qx "Test OK" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
